/* apb_uart.f */
source/uart_pkg.sv
source/sync_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/apb_uart_regs.sv
source/apb_uart.sv
verification/apb_uart_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the APB UART testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f apb_uart.f --top-module apb_uart_tb -o apb_uart_sim
./obj_dir/apb_uart_sim | tee sim.log
if grep -qx "PASS: all tests" sim.log; then
    exit 0
fi
exit 1

/* source/apb_uart.sv */
// APB UART top level
`timescale 1ns/1ps
module apb_uart
    import uart_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp,
    input  logic     rxd,
    output logic     txd
);

    // Transmit path
    logic              tx_wr;
    logic [DATA_W-1:0] tx_din;
    logic              tx_rd;
    logic [DATA_W-1:0] tx_dout;
    logic              tx_full;
    logic              tx_empty;
    logic              tx_busy;

    // Receive path
    logic              rx_wr;
    rx_item_t          rx_din;
    logic              rx_rd;
    rx_item_t          rx_dout;
    logic              rx_full;
    logic              rx_empty;

    logic [BAUD_W-1:0] baud_div;

    apb_uart_regs regs_i (
        .clk      (clk),
        .rst      (rst),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .tx_wr    (tx_wr),
        .tx_din   (tx_din),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .tx_busy  (tx_busy),
        .rx_rd    (rx_rd),
        .rx_dout  (rx_dout),
        .rx_full  (rx_full),
        .rx_empty (rx_empty),
        .rx_wr    (rx_wr),
        .baud_div (baud_div)
    );

    sync_fifo #(.item_t(logic [DATA_W-1:0])) tx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (tx_wr),
        .din   (tx_din),
        .rd    (tx_rd),
        .dout  (tx_dout),
        .full  (tx_full),
        .empty (tx_empty)
    );

    sync_fifo #(.item_t(rx_item_t)) rx_fifo_i (
        .clk   (clk),
        .rst   (rst),
        .wr    (rx_wr),
        .din   (rx_din),
        .rd    (rx_rd),
        .dout  (rx_dout),
        .full  (rx_full),
        .empty (rx_empty)
    );

    uart_tx tx_i (
        .clk        (clk),
        .rst        (rst),
        .baud_div   (baud_div),
        .fifo_empty (tx_empty),
        .fifo_dout  (tx_dout),
        .fifo_rd    (tx_rd),
        .txd        (txd),
        .busy       (tx_busy)
    );

    uart_rx rx_i (
        .clk      (clk),
        .rst      (rst),
        .baud_div (baud_div),
        .rxd      (rxd),
        .fifo_wr  (rx_wr),
        .fifo_din (rx_din)
    );

endmodule

/* source/apb_uart_regs.sv */
// UART APB register block
`timescale 1ns/1ps
module apb_uart_regs
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  apb_req_t          apb_req,
    output apb_rsp_t          apb_rsp,
    output logic              tx_wr,
    output logic [DATA_W-1:0] tx_din,
    input  logic              tx_full,
    input  logic              tx_empty,
    input  logic              tx_busy,
    output logic              rx_rd,
    input  rx_item_t          rx_dout,
    input  logic              rx_full,
    input  logic              rx_empty,
    input  logic              rx_wr,
    output logic [BAUD_W-1:0] baud_div
);

    logic                  setup;
    logic                  access;
    logic                  sel_data;
    logic                  sel_status;
    logic                  sel_baud;
    logic                  status_rd;
    logic                  rd_popped;
    logic                  tx_overflow;
    logic                  rx_overflow;
    uart_status_t          status;
    logic [APB_DATA_W-1:0] rdata;

    // ------------------------------------------------------------------------
    // Phase and address decode
    // ------------------------------------------------------------------------
    assign setup      = apb_req.psel && !apb_req.penable;
    assign access     = apb_req.psel && apb_req.penable;
    assign sel_data   = (apb_req.paddr == REG_DATA);
    assign sel_status = (apb_req.paddr == REG_STATUS);
    assign sel_baud   = (apb_req.paddr == REG_BAUD);

    assign tx_wr     = access && apb_req.pwrite && sel_data;
    assign tx_din    = apb_req.pwdata[DATA_W-1:0];
    assign rx_rd     = setup && !apb_req.pwrite && sel_data && !rx_empty;   // Pop early
    assign status_rd = access && !apb_req.pwrite && sel_status;

    assign status.tx_busy     = tx_busy;
    assign status.rx_overflow = rx_overflow;
    assign status.tx_overflow = tx_overflow;
    assign status.rx_full     = rx_full;
    assign status.rx_empty    = rx_empty;
    assign status.tx_full     = tx_full;
    assign status.tx_empty    = tx_empty;

    // ------------------------------------------------------------------------
    // Read data and response
    // ------------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        if (sel_data && rd_popped) begin
            rdata = {{(APB_DATA_W - $bits(rx_item_t)){1'b0}}, rx_dout};
        end else if (sel_status) begin
            rdata = {{(APB_DATA_W - $bits(uart_status_t)){1'b0}}, status};
        end else if (sel_baud) begin
            rdata = {{(APB_DATA_W - BAUD_W){1'b0}}, baud_div};
        end
    end

    assign apb_rsp.prdata  = rdata;
    assign apb_rsp.pready  = 1'b1;   // Zero wait states
    assign apb_rsp.pslverr = access && !apb_req.pwrite && sel_data && !rd_popped;

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_popped   <= 1'b0;
            tx_overflow <= 1'b0;
            rx_overflow <= 1'b0;
            baud_div    <= BAUD_W'(BAUD_DIV_RESET);
        end else begin
            rd_popped <= rx_rd;
            // New overflow wins over clear
            tx_overflow <= (tx_overflow && !status_rd) || (tx_wr && tx_full);
            rx_overflow <= (rx_overflow && !status_rd) || (rx_wr && rx_full);
            if (access && apb_req.pwrite && sel_baud) begin
                baud_div <= apb_req.pwdata[BAUD_W-1:0];
            end
        end
    end

    a_apb_phase : assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> $past(apb_req.psel && !apb_req.penable))
        else $error("apb_uart_regs: access without setup phase");

endmodule

/* source/sync_fifo.sv */
// Synchronous FIFO
`timescale 1ns/1ps
module sync_fifo
    import uart_pkg::*;
#(
    parameter type item_t = logic [DATA_W-1:0]
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  wr,
    input  item_t din,
    input  logic  rd,
    output item_t dout,
    output logic  full,
    output logic  empty
);

    item_t                 mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic [FIFO_CNT_W-1:0] count_next;
    logic                  do_wr;
    logic                  do_rd;

    assign do_wr = wr && !full;    // Push into full FIFO is lost
    assign do_rd = rd && !empty;

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Storage and read port
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
        if (do_rd) begin
            dout <= mem[rd_ptr];   // Held until next pop
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, count and flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps since depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == FIFO_CNT_W'(FIFO_DEPTH));
            empty <= (count_next == '0);
        end
    end

    a_count_bound : assert property (@(posedge clk) disable iff (rst)
        count <= FIFO_CNT_W'(FIFO_DEPTH))
        else $error("sync_fifo: count above depth");

    a_flags_ptrs : assert property (@(posedge clk) disable iff (rst)
        (full || empty) |-> (wr_ptr == rd_ptr))
        else $error("sync_fifo: flag disagrees with pointers");

endmodule

/* source/uart_pkg.sv */
// UART shared definitions
package uart_pkg;

    // ------------------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------------------
    localparam int DATA_W         = 8;
    localparam int FRAME_W        = DATA_W + 2;   // Start, data, stop
    localparam int FIFO_DEPTH     = 8;
    localparam int FIFO_PTR_W     = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W     = $clog2(FIFO_DEPTH + 1);
    localparam int ADDR_W         = 4;
    localparam int APB_DATA_W     = 32;
    localparam int BAUD_W         = 16;
    localparam int BAUD_DIV_RESET = 16;           // Clocks per bit

    // Register offsets
    localparam logic [ADDR_W-1:0] REG_DATA   = 4'h0;
    localparam logic [ADDR_W-1:0] REG_STATUS = 4'h4;
    localparam logic [ADDR_W-1:0] REG_BAUD   = 4'h8;

    // ------------------------------------------------------------------------
    // Bus and payload types
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0]     paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic              frame_err;   // Stop bit sampled low
        logic [DATA_W-1:0] data;
    } rx_item_t;

    typedef struct packed {
        logic tx_busy;
        logic rx_overflow;
        logic tx_overflow;
        logic rx_full;
        logic rx_empty;
        logic tx_full;
        logic tx_empty;   // Bit 0
    } uart_status_t;

endpackage

/* source/uart_rx.sv */
// UART 8N1 receiver
`timescale 1ns/1ps
module uart_rx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [BAUD_W-1:0] baud_div,
    input  logic              rxd,
    output logic              fifo_wr,
    output rx_item_t          fifo_din
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         state;
    logic              rxd_meta;
    logic              rxd_sync;
    logic              rxd_prev;
    logic [BAUD_W-1:0] baud_cnt;
    logic [BAUD_W-1:0] half_div;
    logic [2:0]        bit_cnt;
    logic [DATA_W-1:0] shreg;
    logic              half_end;
    logic              bit_end;
    logic              sample_data;
    logic              push;

    assign half_div    = baud_div >> 1;
    assign half_end    = (baud_cnt == half_div - 1'b1);
    assign bit_end     = (baud_cnt == baud_div - 1'b1);
    assign sample_data = (state == RX_DATA) && bit_end;
    assign push        = (state == RX_STOP) && bit_end;

    // ------------------------------------------------------------------------
    // Line synchronizer and frame FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            state    <= RX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            fifo_wr  <= 1'b0;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            fifo_wr  <= push;
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                RX_IDLE: begin
                    baud_cnt <= '0;
                    if (rxd_prev && !rxd_sync) begin
                        state <= RX_START;   // Falling edge
                    end
                end
                RX_START: begin
                    if (half_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // Glitch, not a start bit
                        state    <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(DATA_W - 1)) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Data capture
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (sample_data) begin
            shreg <= {rxd_sync, shreg[DATA_W-1:1]};   // LSB first
        end
        if (push) begin
            fifo_din.frame_err <= !rxd_sync;
            fifo_din.data      <= shreg;
        end
    end

    a_wr_pulse : assert property (@(posedge clk) disable iff (rst)
        fifo_wr |=> !fifo_wr)
        else $error("uart_rx: push longer than one cycle");

endmodule

/* source/uart_tx.sv */
// UART 8N1 transmitter
`timescale 1ns/1ps
module uart_tx
    import uart_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [BAUD_W-1:0] baud_div,
    input  logic              fifo_empty,
    input  logic [DATA_W-1:0] fifo_dout,
    output logic              fifo_rd,
    output logic              txd,
    output logic              busy
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_FETCH,
        TX_SHIFT
    } tx_state_t;

    tx_state_t          state;
    logic [BAUD_W-1:0]  baud_cnt;
    logic [3:0]         bit_cnt;
    logic [FRAME_W-1:0] shreg;
    logic               bit_end;

    assign fifo_rd = (state == TX_IDLE) && !fifo_empty;
    assign bit_end = (baud_cnt == baud_div - 1'b1);
    assign txd     = shreg[0];                     // Line idles high
    assign busy    = fifo_rd || (state != TX_IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            shreg    <= '1;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (fifo_rd) begin
                        state <= TX_FETCH;
                    end
                end
                TX_FETCH: begin
                    // FIFO output is valid now
                    shreg    <= {1'b1, fifo_dout, 1'b0};
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    state    <= TX_SHIFT;
                end
                TX_SHIFT: begin
                    if (bit_end) begin
                        baud_cnt <= '0;
                        shreg    <= {1'b1, shreg[FRAME_W-1:1]};
                        if (bit_cnt == 4'(FRAME_W - 1)) begin
                            state <= TX_IDLE;   // Stop bit done
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    a_rd_start : assert property (@(posedge clk) disable iff (rst)
        $past(fifo_rd, 2) |-> !txd)
        else $error("uart_tx: pop not followed by start bit");

endmodule

/* verification/apb_uart_tb.sv */
// APB UART testbench
`timescale 1ns/1ps
module apb_uart_tb
    import uart_pkg::*;
();

    logic     clk = 1'b0;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    logic     rxd;
    logic     txd;
    logic     loopback;     // 1 routes txd back to rxd
    logic     line_drv;

    rx_item_t expected_q [$];
    rx_item_t observed_q [$];
    int       errors = 0;
    int       timeouts = 0;
    int       compare_errors = 0;
    int       compared = 0;
    integer   seed;

    assign rxd = loopback ? txd : line_drv;

    apb_uart dut_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .rxd     (rxd),
        .txd     (txd)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Reference model and compare
    // ------------------------------------------------------------------------
    function automatic rx_item_t expected_item(input logic [DATA_W-1:0] b,
                                               input logic stop_bit);
        rx_item_t item;
        item.frame_err = !stop_bit;   // Stop must be sampled high
        item.data      = b;
        return item;
    endfunction

    always @(posedge clk) begin
        if (compared < observed_q.size()) begin
            assert (compared < expected_q.size()) else begin
                compare_errors++;
                $display("Read number %0d arrived with no byte expected", compared);
            end
            if (compared < expected_q.size()) begin
                assert (observed_q[compared] == expected_q[compared]) else begin
                    compare_errors++;
                    $display("Fail at %0t: read %0d got 0x%03h, expected 0x%03h", $time,
                             compared, observed_q[compared], expected_q[compared]);
                end
            end
            compared++;
        end
    end

    task automatic finish_run();
        $display("Errors: %0d, compare errors: %0d, timeouts: %0d, reads compared: %0d",
                 errors, compare_errors, timeouts, compared);
        if (errors == 0 && compare_errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            errors++;
            $display("Fail at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_pready();
        assert (apb_rsp.pready) else begin
            errors++;
            $display("Fail at %0t: pready low in access cycle", $time);
        end
    endtask

    // ------------------------------------------------------------------------
    // APB master
    // ------------------------------------------------------------------------
    task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b1;
        apb_req.pwdata  = data;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);
        check_pready();
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        apb_req.paddr   = addr;
        apb_req.pwrite  = 1'b0;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #1;
        apb_req.penable = 1'b1;
        @(negedge clk);                   // Mid access cycle
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        check_pready();
        @(posedge clk);
        #1;
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic read_rx_item();
        logic [31:0] d;
        logic        e;
        apb_read(REG_DATA, d, e);
        assert (!e) else begin
            errors++;
            $display("Fail at %0t: DATA read with a byte waiting returned pslverr", $time);
        end
        observed_q.push_back(rx_item_t'(d[8:0]));
    endtask

    // Polls STATUS until bit idx equals value
    task automatic wait_status_bit(input int idx, input logic value, input int limit,
                                   input string what);
        logic [31:0] d;
        logic        e;
        int          polls;
        polls = 0;
        do begin
            apb_read(REG_STATUS, d, e);
            polls++;
        end while (d[idx] != value && polls < limit);
        if (d[idx] != value) begin
            timeouts++;
            $display("Timeout at %0t: gave up waiting for %s after %0d polls", $time, what,
                     polls);
        end
    endtask

    task automatic send_frame(input logic [DATA_W-1:0] b, input logic stop_bit,
                              input int div);
        logic [FRAME_W-1:0] frame;
        frame = {stop_bit, b, 1'b0};
        for (int i = 0; i < FRAME_W; i++) begin
            @(posedge clk);
            #1;
            line_drv = frame[i];
            repeat (div - 1) @(posedge clk);
        end
        @(posedge clk);
        #1;
        line_drv = 1'b1;
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [31:0]       d;
        logic              e;
        logic [DATA_W-1:0] b;
        uart_status_t      st;
        uart_status_t      st_before;
        uart_status_t      exp_st;
        int                i;
        int                n;
        rst      = 1'b1;
        apb_req  = '0;
        loopback = 1'b1;
        line_drv = 1'b1;
        seed     = 32'h86c1_4a03;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        exp_st          = '0;
        exp_st.tx_empty = 1'b1;
        exp_st.rx_empty = 1'b1;
        apb_read(REG_STATUS, d, e);
        check_value("reset STATUS", d, 32'(exp_st));
        apb_read(REG_BAUD, d, e);
        check_value("reset BAUD", d, 32'(BAUD_DIV_RESET));

        // Loopback one byte at a time
        apb_write(REG_BAUD, 32'd8);
        repeat (6) begin
            b = DATA_W'($random(seed));
            expected_q.push_back(expected_item(b, 1'b1));
            apb_write(REG_DATA, {24'd0, b});
            wait_status_bit(2, 1'b0, 12 * 8, "loopback byte");
            read_rx_item();
        end

        // Transmit overflow with the first byte already popped
        apb_write(REG_BAUD, 32'd200);
        for (i = 0; i < FIFO_DEPTH + 3; i++) begin
            b = DATA_W'($random(seed));
            if (i < FIFO_DEPTH + 1) begin
                expected_q.push_back(expected_item(b, 1'b1));
            end
            apb_write(REG_DATA, {24'd0, b});
        end
        apb_read(REG_STATUS, d, e);
        st = uart_status_t'(d[6:0]);
        assert (st.tx_overflow && st.tx_full) else begin
            errors++;
            $display("Fail at %0t: STATUS 0x%02h lacks tx_overflow or tx_full", $time, st);
        end
        apb_read(REG_STATUS, d, e);
        st = uart_status_t'(d[6:0]);
        assert (!st.tx_overflow) else begin
            errors++;
            $display("Fail at %0t: tx_overflow still set after STATUS read", $time);
        end
        repeat (FIFO_DEPTH + 1) begin
            wait_status_bit(2, 1'b0, 12 * 200, "byte after overflow");
            read_rx_item();
        end
        wait_status_bit(6, 1'b0, 12 * 200, "transmitter idle");

        // Hand-built frame with the stop bit low
        apb_write(REG_BAUD, 32'd8);
        @(posedge clk);
        #1;
        loopback = 1'b0;
        b = DATA_W'($random(seed));
        expected_q.push_back(expected_item(b, 1'b0));
        send_frame(b, 1'b0, 8);
        wait_status_bit(2, 1'b0, 12 * 8, "framing error byte");
        read_rx_item();

        // DATA read from an empty receive FIFO
        apb_read(REG_STATUS, d, e);
        st_before = uart_status_t'(d[6:0]);
        apb_read(REG_DATA, d, e);
        assert (e === 1'b1) else begin
            errors++;
            $display("Fail at %0t: empty DATA read returned no pslverr", $time);
        end
        check_value("empty DATA", d, 32'd0);
        apb_read(REG_STATUS, d, e);
        st                    = uart_status_t'(d[6:0]);
        st.tx_overflow        = 1'b0;
        st.rx_overflow        = 1'b0;
        st_before.tx_overflow = 1'b0;
        st_before.rx_overflow = 1'b0;
        check_value("STATUS after empty read", 32'(st), 32'(st_before));

        n = 0;
        while (compared < observed_q.size() && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (compared < observed_q.size()) begin
            timeouts++;
            $display("Timeout at %0t: compare process did not finish", $time);
        end
        assert (compared == expected_q.size()) else begin
            errors++;
            $display("Only %0d of %0d expected bytes were read", compared,
                     expected_q.size());
        end
        finish_run();
    end

endmodule
